//--- bench/predecodeVectors.svh
//======================================================================
// predecoder stimulus table with expected counts and error flags
//======================================================================

localparam int NUM_VECTORS = 14;

// columns: bundle (parcel 7 down to parcel 0), endBits, startOff,
// instructions, jumps, bundleError, jumpError
function automatic vector_t vectorRow(int idx);
  vector_t v;
  case (idx)
    // lengths 1, 2, 3, 2
    0: v = '{128'h0000_00A0_5555_ABCD_0050_1234_0003_0011, 8'hA5, 3'd0, 4'd4, 4'd1, 1'b0, 1'b0};
    // skips parcels 0..2, jump at parcel 6 has no end bit
    1: v = '{128'hFFFF_00A0_0007_2222_00F0_1111_2222_3333, 8'h32, 3'd3, 4'd2, 4'd0, 1'b0, 1'b0};
    // alu, mul, shift (xor), shift
    2: v = '{128'h1007_0028_1005_0021_1003_0005_1001_0001, 8'hAA, 3'd0, 4'd4, 4'd0, 1'b0, 1'b0};
    // load, store, fpu, sys
    3: v = '{128'h1007_00FF_1005_00F0_1003_0041_1001_0040, 8'hAA, 3'd0, 4'd4, 4'd0, 1'b0, 1'b0};
    // sys 201, nothing, mul, nothing
    4: v = '{128'h1007_0080_1005_0024_1003_0033_1001_00C9, 8'hAA, 3'd0, 4'd4, 4'd0, 1'b0, 1'b0};
    5: v = '{128'h1007_0040_1005_00B2_1003_0001_1001_00A0, 8'hAA, 3'd0, 4'd4, 4'd2, 1'b0, 1'b0};
    // op 182 with fn 0, 1, 3 and 4, third jump overflows
    6: v = '{128'h1007_80B6_1005_60B6_1003_20B6_1001_00B6, 8'hAA, 3'd0, 4'd4, 4'd3, 1'b0, 1'b1};
    7: v = '{128'h1007_0011_1005_00AF_1003_00B0_1001_40B6, 8'hAA, 3'd0, 4'd4, 4'd2, 1'b0, 1'b0};
    // eight and seven single parcels
    8: v = '{128'h0008_0007_0006_0005_0004_0003_0002_0001, 8'hFF, 3'd0, 4'd8, 4'd0, 1'b1, 1'b0};
    9: v = '{128'h0008_0007_0006_0005_0004_0003_0002_0001, 8'hFF, 3'd1, 4'd7, 4'd0, 1'b1, 1'b0};
    // four parcels at 0..3
    10: v = '{128'h1111_0001_2222_00A5_3333_4444_5555_0040, 8'hA8, 3'd0, 4'd2, 4'd1, 1'b1, 1'b0};
    11: v = '{128'h7777_6666_00A1_0000_0000_0000_0000_0000, 8'h80, 3'd5, 4'd1, 4'd1, 1'b0, 1'b0};
    // no end bit anywhere
    12: v = '{128'h0102_0304_0506_0708_090A_0B0C_0D0E_0F10, 8'h00, 3'd2, 4'd0, 4'd0, 1'b0, 1'b0};
    13: v = '{128'h9999_00B4_8888_00A0_0004_0003_0002_0001, 8'hAF, 3'd0, 4'd6, 4'd2, 1'b0, 1'b0};
    default: v = '0;
  endcase
  return v;
endfunction

//--- bench/predecodeTb.sv
//======================================================================
// predecoder testbench: table and random bundles checked against a
// model of the start, length and class rules
//======================================================================

`include "predecode_config.svh"

module predecodeTb;
  timeunit 1ns;
  timeprecision 100ps;
  import predecodePkg::*;

  localparam int N          = `PD_PARCELS;
  localparam int TIMEOUT    = 20;
  localparam int NUM_RANDOM = 40;

  typedef logic [N-1:0][`PD_PARCEL_BITS-1:0] bundle_t;

  typedef struct packed {
    bundle_t      bundle;
    logic [N-1:0] endBits;
    offset_t      startOff;
    logic [3:0]   nInst;    // complete instructions before the slot limit
    logic [3:0]   nJump;
    logic         bundleError;
    logic         jumpError;
  } vector_t;

  typedef struct packed {
    instrSlot_t [`PD_INSTR_SLOTS-1:0] slots;
    logic [`PD_INSTR_SLOTS-1:0]       slotEn;
    jumpSlot_t [`PD_JUMP_SLOTS-1:0]   jumps;
    logic [`PD_JUMP_SLOTS-1:0]        jumpEn;
    logic                             hasJumps;
    logic                             bundleError;
    logic                             jumpError;
  } result_t;

  logic                             clk;
  logic                             reset;
  logic                             inValid;
  bundle_t                          bundle;
  logic [N-1:0]                     endBits;
  offset_t                          startOff;
  logic                             outValid;
  instrSlot_t [`PD_INSTR_SLOTS-1:0] slots;
  logic [`PD_INSTR_SLOTS-1:0]       slotEn;
  jumpSlot_t [`PD_JUMP_SLOTS-1:0]   jumps;
  logic [`PD_JUMP_SLOTS-1:0]        jumpEn;
  logic                             hasJumps;
  logic                             bundleError;
  logic                             jumpError;

  logic [31:0] rngState;
  result_t     pending[$];   // results still in flight

  `include "predecodeVectors.svh"

  predecodeTop i_dut (
    .clk         (clk),
    .reset       (reset),
    .inValid     (inValid),
    .bundle      (bundle),
    .endBits     (endBits),
    .startOff    (startOff),
    .outValid    (outValid),
    .slots       (slots),
    .slotEn      (slotEn),
    .jumps       (jumps),
    .jumpEn      (jumpEn),
    .hasJumps    (hasJumps),
    .bundleError (bundleError),
    .jumpError   (jumpError)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] xorshift();
    logic [31:0] x;
    x = rngState;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rngState = x;
    return x;
  endfunction

  function automatic iclass_t classOf(window_t w, int len);
    iclass_t c;
    int op;
    int fn;
    c  = '0;
    op = int'(w[0][7:0]);
    fn = int'(w[0][15:13]);
    if (len == 1) c.alu = 1'b1;
    else if (op <= 39 && ((op >> 2) & 1) == 1) c.mul = 1'b1;
    else if (op <= 31) c.alu = 1'b1;
    else if (op <= 45) c.shift = 1'b1;   // 32..35 and 40..45
    else if (op >= 64 && op <= 127) begin
      c.load  = (op % 2 == 0);
      c.store = (op % 2 == 1);
    end else if ((op >= 160 && op <= 175) || (op >= 178 && op <= 181)) c.jump = 1'b1;
    else if (op == 182) begin
      c.jump  = (fn <= 3);
      c.indir = (fn == 0 || fn == 3);
      c.store = (fn == 1 || fn == 2);
    end else if (op == 240) c.fpu = 1'b1;
    else if (op == 255 || op == 201) c.sys = 1'b1;
    return c;
  endfunction

  // reference model of one bundle
  function automatic result_t predict(bundle_t b, logic [N-1:0] e, offset_t off);
    result_t    r;
    window_t    w;
    iclass_t    c;
    logic [N:0] prevEnd;
    int         first;
    int         len;
    int         nInst;
    int         nJump;
    bit         head;
    bit         later;
    r       = '0;
    prevEnd = {e, 1'b0};
    first   = int'(off);
    nInst   = 0;
    nJump   = 0;
    for (int k = 0; k < N; k++) begin
      head  = k >= first && (k == first || prevEnd[k]);
      len   = 0;
      later = 1'b0;
      w     = '0;
      for (int m = 0; m < `PD_MAX_PARCELS; m++) begin
        if (k + m < N) begin
          w[m] = b[k+m];
          if (len == 0 && e[k+m]) len = m + 1;
        end
      end
      for (int j = k + `PD_MAX_PARCELS; j < N; j++) later |= e[j];
      if (head && len == 0 && later) r.bundleError = 1'b1;   // over three parcels
      if (head && len != 0) begin
        c = classOf(w, len);
        if (nInst < `PD_INSTR_SLOTS) begin
          r.slots[nInst].window = w;
          r.slots[nInst].offset = offset_t'(k);
          r.slots[nInst].length = length_t'(len);
          r.slots[nInst].cls    = c;
          r.slotEn[nInst]       = 1'b1;
        end
        nInst++;
        if (c.jump) begin
          if (nJump < `PD_JUMP_SLOTS) begin
            r.jumps[nJump].window = w;
            r.jumps[nJump].offset = offset_t'(k);
            r.jumpEn[nJump]       = 1'b1;
          end
          nJump++;
          r.hasJumps = 1'b1;
        end
      end
    end
    if (nInst > `PD_INSTR_SLOTS) r.bundleError = 1'b1;
    r.jumpError = nJump > `PD_JUMP_SLOTS;
    return r;
  endfunction

  task automatic abortRun();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic checkSlot(string name, instrSlot_t got, instrSlot_t want);
    if (got !== want) begin
      $display("FAILED %s: got %h, expected %h", name, got, want);
      abortRun();
    end
  endtask

  task automatic checkJump(string name, jumpSlot_t got, jumpSlot_t want);
    if (got !== want) begin
      $display("FAILED %s: got %h, expected %h", name, got, want);
      abortRun();
    end
  endtask

  task automatic checkFlag(string name, logic got, logic want);
    if (got !== want) begin
      $display("FAILED %s: got %h, expected %h", name, got, want);
      abortRun();
    end
  endtask

  task automatic checkCount(string name, int got, int want);
    if (got != want) begin
      $display("FAILED %s: got %h, expected %h", name, got, want);
      abortRun();
    end
  endtask

  task automatic waitOutValid();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!outValid) begin
      if (cycles == TIMEOUT) begin
        $display("timed out waiting for outValid after a bundle");
        abortRun();
      end
      cycles++;
      @(negedge clk);
    end
  endtask

  task automatic compareResult(result_t want);
    for (int s = 0; s < `PD_INSTR_SLOTS; s++) begin
      checkSlot($sformatf("slots[%0d]", s), slots[s], want.slots[s]);
      checkFlag($sformatf("slotEn[%0d]", s), slotEn[s], want.slotEn[s]);
    end
    for (int j = 0; j < `PD_JUMP_SLOTS; j++) begin
      checkJump($sformatf("jumps[%0d]", j), jumps[j], want.jumps[j]);
      checkFlag($sformatf("jumpEn[%0d]", j), jumpEn[j], want.jumpEn[j]);
    end
    checkFlag("hasJumps", hasJumps, want.hasJumps);
    checkFlag("bundleError", bundleError, want.bundleError);
    checkFlag("jumpError", jumpError, want.jumpError);
  endtask

  task automatic applyRow(vector_t v);
    result_t want;
    int      expInst;
    int      expJump;
    want    = predict(v.bundle, v.endBits, v.startOff);
    expInst = (int'(v.nInst) > `PD_INSTR_SLOTS) ? `PD_INSTR_SLOTS : int'(v.nInst);
    expJump = (int'(v.nJump) > `PD_JUMP_SLOTS) ? `PD_JUMP_SLOTS : int'(v.nJump);
    @(posedge clk);
    inValid  <= 1'b1;
    bundle   <= v.bundle;
    endBits  <= v.endBits;
    startOff <= v.startOff;
    @(posedge clk);
    inValid <= 1'b0;
    waitOutValid();
    checkCount("slotEn count", $countones(slotEn), expInst);
    checkCount("jumpEn count", $countones(jumpEn), expJump);
    checkFlag("hasJumps", hasJumps, v.nJump != 0);
    checkFlag("bundleError", bundleError, v.bundleError);
    checkFlag("jumpError", jumpError, v.jumpError);
    compareResult(want);
    @(negedge clk);   // result holds through an idle cycle
    checkFlag("outValid", outValid, 1'b0);
    compareResult(want);
  endtask

  // one bundle per cycle with each result due one cycle later
  task automatic runBackToBack();
    logic [31:0]  rnd;
    bundle_t      b;
    logic [N-1:0] e;
    offset_t      off;
    for (int i = 0; i <= NUM_RANDOM; i++) begin
      @(posedge clk);
      if (i < NUM_RANDOM) begin
        for (int p = 0; p < N; p++) begin
          rnd  = xorshift();
          b[p] = rnd[15:0];
        end
        rnd = xorshift();
        e   = rnd[7:0];
        off = {1'b0, rnd[9:8]};   // early starts leave room for more instructions
        pending.push_back(predict(b, e, off));
        inValid  <= 1'b1;
        bundle   <= b;
        endBits  <= e;
        startOff <= off;
      end else begin
        inValid <= 1'b0;
      end
      @(negedge clk);
      if (i > 0) begin
        checkFlag("outValid", outValid, 1'b1);
        compareResult(pending.pop_front());
      end
    end
  endtask

  initial begin
    rngState = 32'd63;
    reset    <= 1'b1;
    inValid  <= 1'b0;
    bundle   <= '0;
    endBits  <= '0;
    startOff <= '0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    checkFlag("outValid", outValid, 1'b0);
    for (int s = 0; s < `PD_INSTR_SLOTS; s++) begin
      checkFlag($sformatf("slotEn[%0d]", s), slotEn[s], 1'b0);
    end
    for (int j = 0; j < `PD_JUMP_SLOTS; j++) begin
      checkFlag($sformatf("jumpEn[%0d]", j), jumpEn[j], 1'b0);
    end
    checkFlag("hasJumps", hasJumps, 1'b0);
    checkFlag("bundleError", bundleError, 1'b0);
    checkFlag("jumpError", jumpError, 1'b0);
    for (int i = 0; i < NUM_VECTORS; i++) begin
      applyRow(vectorRow(i));
    end
    runBackToBack();
    $display("Everything OK");
    $finish;
  end

endmodule

//--- common/parcelBus.sv
//======================================================================
// per-parcel decode results, boundary scan to slot selection
//======================================================================

`include "predecode_config.svh"

interface parcelBus ();
  import predecodePkg::*;

  logic    [`PD_PARCELS-1:0] start;      // complete instruction starts here
  window_t [`PD_PARCELS-1:0] window;
  length_t [`PD_PARCELS-1:0] length;
  iclass_t [`PD_PARCELS-1:0] cls;        // from the classifiers
  rank_t   [`PD_PARCELS-1:0] instRank;
  rank_t   [`PD_PARCELS-1:0] jumpRank;

  modport scan (
    output start, window, length, instRank, jumpRank,
    input  cls
  );

  modport sel (
    input start, window, length, cls, instRank, jumpRank
  );

endinterface

//--- common/predecodePkg.sv
//======================================================================
// predecoder types: instruction class flags, slot layouts, indices
//======================================================================

`include "predecode_config.svh"

package predecodePkg;

  typedef struct packed {
    logic jump;
    logic indir;
    logic alu;
    logic shift;
    logic mul;
    logic load;
    logic store;
    logic fpu;
    logic sys;
  } iclass_t;

  typedef logic [$clog2(`PD_PARCELS)-1:0] offset_t;
  typedef logic [$clog2(`PD_PARCELS)-1:0] rank_t;    // order among taken parcels
  typedef logic [$clog2(`PD_MAX_PARCELS+1)-1:0] length_t;

  // parcel 0 of the window is the parcel at the start position
  typedef logic [`PD_MAX_PARCELS-1:0][`PD_PARCEL_BITS-1:0] window_t;

  typedef struct packed {
    window_t window;
    offset_t offset;
    length_t length;
    iclass_t cls;
  } instrSlot_t;

  typedef struct packed {
    window_t window;
    offset_t offset;
  } jumpSlot_t;

endpackage

//--- common/predecode_config.svh
//======================================================================
// predecoder configuration
// bundle geometry, longest instruction and output slot counts
//======================================================================

`ifndef PREDECODE_CONFIG_SVH
`define PREDECODE_CONFIG_SVH

// one parcel is the smallest instruction unit
`define PD_PARCEL_BITS 16
`define PD_PARCELS 8

// longest instruction in parcels, also the window read at each start
`define PD_MAX_PARCELS 3

// output side
`define PD_INSTR_SLOTS 6
`define PD_JUMP_SLOTS 2

`endif

//--- compile.f
+incdir+common
+incdir+bench
common/predecodePkg.sv
common/parcelBus.sv
hw/predecoder/instrClassifier.sv
hw/predecoder/boundaryScan.sv
hw/predecoder/slotSelector.sv
hw/predecoder/predecodeTop.sv
bench/predecodeTb.sv

//--- hw/predecoder/boundaryScan.sv
//======================================================================
// boundary scan: instruction starts, lengths, ranks and bundle flags
//======================================================================

`include "predecode_config.svh"

module boundaryScan (
  input  logic [`PD_PARCELS-1:0][`PD_PARCEL_BITS-1:0] bundle,
  input  logic [`PD_PARCELS-1:0]                      endBits,
  input  predecodePkg::offset_t                       startOff,
  parcelBus.scan                                      bus,
  output logic                                        bundleError,
  output logic                                        jumpError,
  output logic                                        hasJumps
);
  import predecodePkg::*;

  localparam int N = `PD_PARCELS;
  localparam int W = `PD_PARCEL_BITS;
  localparam int M = `PD_MAX_PARCELS;

  logic [N+M-2:0][W-1:0] padded;    // zero parcels past the bundle end
  logic [N+M-2:0]        endPad;
  logic [N-1:0]          prevEnd;
  logic [N-1:0]          head;      // start rule only
  logic [N-1:0]          tooLong;
  logic [$clog2(N):0]    instCnt;
  logic [$clog2(N):0]    jumpCnt;

  assign padded  = {{((M-1)*W){1'b0}}, bundle};
  assign endPad  = {{(M-1){1'b0}}, endBits};
  assign prevEnd = {endBits[N-2:0], 1'b0};

  always_comb begin
    instCnt = '0;
    for (int k = 0; k < N; k++) begin
      head[k] = (offset_t'(k) >= startOff) &&
                (offset_t'(k) == startOff || prevEnd[k]);
      bus.window[k] = padded[k +: M];

      // nearest end bit inside the window wins
      bus.length[k] = '0;
      for (int m = M - 1; m >= 0; m--) begin
        if (endPad[k+m]) bus.length[k] = length_t'(m + 1);
      end

      // an end bit further out means the instruction is too long
      tooLong[k]   = head[k] && bus.length[k] == '0 && (endBits >> (k + M)) != '0;
      bus.start[k] = head[k] && bus.length[k] != '0;

      bus.instRank[k] = rank_t'(instCnt);
      if (bus.start[k]) instCnt = instCnt + 1'b1;
    end
    bundleError = (instCnt > `PD_INSTR_SLOTS) || (tooLong != '0);
  end

  // kept apart from the start logic, the class depends on window and length
  always_comb begin
    jumpCnt = '0;
    for (int k = 0; k < N; k++) begin
      bus.jumpRank[k] = rank_t'(jumpCnt);
      if (bus.start[k] && bus.cls[k].jump) jumpCnt = jumpCnt + 1'b1;
    end
    jumpError = jumpCnt > `PD_JUMP_SLOTS;
    hasJumps  = jumpCnt != '0;
  end

endmodule

//--- hw/predecoder/instrClassifier.sv
//======================================================================
// instruction classifier: opcode byte of one parcel position to
// execution class flags
//======================================================================

module instrClassifier (
  input  predecodePkg::window_t window,
  input  predecodePkg::length_t length,
  output predecodePkg::iclass_t cls
);

  logic [7:0] op;
  logic [2:0] fn;

  assign op = window[0][7:0];
  assign fn = window[0][15:13];   // only meaningful for op 182

  always_comb begin
    cls = '0;
    if (length == 2'd1) begin
      cls.alu = 1'b1;   // compressed forms not split further
    end else begin
      case (op) inside
        [8'd0:8'd39]: begin
          if (op[2]) begin
            cls.mul = 1'b1;
          end else if (op[5]) begin
            cls.shift = 1'b1;   // xor group sits on the shifter
          end else begin
            cls.alu = 1'b1;
          end
        end

        [8'd40:8'd45]: cls.shift = 1'b1;

        [8'd64:8'd127]: begin
          cls.load  = ~op[0];
          cls.store = op[0];
        end

        // conditional, self-test, long and unconditional jumps
        [8'd160:8'd175], [8'd178:8'd181]: cls.jump = 1'b1;

        8'd182: begin
          case (fn)
            3'd0: begin
              cls.jump  = 1'b1;
              cls.indir = 1'b1;
            end
            3'd1, 3'd2: begin   // call pushes the return address
              cls.jump  = 1'b1;
              cls.store = 1'b1;
            end
            3'd3: begin         // return
              cls.jump  = 1'b1;
              cls.indir = 1'b1;
            end
            default: ;
          endcase
        end

        8'hF0: cls.fpu = 1'b1;

        8'hFF, 8'd201: cls.sys = 1'b1;

        default: ;
      endcase
    end
  end

endmodule

//--- hw/predecoder/predecodeTop.sv
//======================================================================
// predecoder top: boundary scan, classifiers, slot packing and the
// output register
//======================================================================

`include "predecode_config.svh"

module predecodeTop (
  input  logic                                          clk,
  input  logic                                          reset,
  input  logic                                          inValid,
  input  logic [`PD_PARCELS-1:0][`PD_PARCEL_BITS-1:0]   bundle,
  input  logic [`PD_PARCELS-1:0]                        endBits,
  input  predecodePkg::offset_t                         startOff,
  output logic                                          outValid,
  output predecodePkg::instrSlot_t [`PD_INSTR_SLOTS-1:0] slots,
  output logic [`PD_INSTR_SLOTS-1:0]                    slotEn,
  output predecodePkg::jumpSlot_t [`PD_JUMP_SLOTS-1:0]  jumps,
  output logic [`PD_JUMP_SLOTS-1:0]                     jumpEn,
  output logic                                          hasJumps,
  output logic                                          bundleError,
  output logic                                          jumpError
);
  import predecodePkg::*;

  localparam int N = `PD_PARCELS;

  parcelBus bus ();

  instrSlot_t [N-1:0]                   instrItems;
  jumpSlot_t  [N-1:0]                   jumpItems;
  logic       [N-1:0]                   jumpTake;
  instrSlot_t [`PD_INSTR_SLOTS-1:0]     nextSlots;
  logic       [`PD_INSTR_SLOTS-1:0]     nextSlotEn;
  jumpSlot_t  [`PD_JUMP_SLOTS-1:0]      nextJumps;
  logic       [`PD_JUMP_SLOTS-1:0]      nextJumpEn;
  logic                                 nextHasJumps;
  logic                                 nextBundleError;
  logic                                 nextJumpError;

  boundaryScan i_scan (
    .bundle      (bundle),
    .endBits     (endBits),
    .startOff    (startOff),
    .bus         (bus),
    .bundleError (nextBundleError),
    .jumpError   (nextJumpError),
    .hasJumps    (nextHasJumps)
  );

  // one classifier per parcel position, results go back onto the bus
  for (genvar k = 0; k < N; k++) begin : g_cls
    instrClassifier i_cls (
      .window (bus.window[k]),
      .length (bus.length[k]),
      .cls    (bus.cls[k])
    );
  end

  always_comb begin
    for (int k = 0; k < N; k++) begin
      instrItems[k].window = bus.window[k];
      instrItems[k].offset = offset_t'(k);
      instrItems[k].length = bus.length[k];
      instrItems[k].cls    = bus.cls[k];
      jumpItems[k].window  = bus.window[k];
      jumpItems[k].offset  = offset_t'(k);
      jumpTake[k]          = bus.start[k] & bus.cls[k].jump;
    end
  end

  slotSelector #(.payload_t(instrSlot_t), .SLOTS(`PD_INSTR_SLOTS)) i_instSel (
    .items  (instrItems),
    .take   (bus.start),
    .rank   (bus.instRank),
    .slots  (nextSlots),
    .slotEn (nextSlotEn)
  );

  slotSelector #(.payload_t(jumpSlot_t), .SLOTS(`PD_JUMP_SLOTS)) i_jumpSel (
    .items  (jumpItems),
    .take   (jumpTake),
    .rank   (bus.jumpRank),
    .slots  (nextJumps),
    .slotEn (nextJumpEn)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      outValid    <= 1'b0;
      slotEn      <= '0;
      jumpEn      <= '0;
      hasJumps    <= 1'b0;
      bundleError <= 1'b0;
      jumpError   <= 1'b0;
    end else begin
      outValid <= inValid;
      if (inValid) begin   // idle cycles hold the last result
        slotEn      <= nextSlotEn;
        jumpEn      <= nextJumpEn;
        hasJumps    <= nextHasJumps;
        bundleError <= nextBundleError;
        jumpError   <= nextJumpError;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (inValid) begin
      slots <= nextSlots;
      jumps <= nextJumps;
    end
  end

endmodule

//--- hw/predecoder/slotSelector.sv
//======================================================================
// slot selector: packs ranked parcel items into output slots
//======================================================================

`include "predecode_config.svh"

module slotSelector #(
  parameter type payload_t = logic,
  parameter int  SLOTS     = 1
) (
  input  payload_t [`PD_PARCELS-1:0]             items,
  input  logic [`PD_PARCELS-1:0]                 take,
  input  predecodePkg::rank_t [`PD_PARCELS-1:0]  rank,
  output payload_t [SLOTS-1:0]                   slots,
  output logic [SLOTS-1:0]                       slotEn
);

  localparam int N = `PD_PARCELS;

  // ranks of taken items are unique, so one match per slot at most
  always_comb begin
    slots  = '0;
    slotEn = '0;
    for (int s = 0; s < SLOTS; s++) begin
      for (int k = 0; k < N; k++) begin
        if (take[k] && int'(rank[k]) == s) begin
          slots[s]  = items[k];
          slotEn[s] = 1'b1;
        end
      end
    end
  end

endmodule

//--- run.sh
#!/usr/bin/env bash
# build the predecoder testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps -f compile.f \
  --top-module predecodeTb -Mdir obj_dir

simOut=$(./obj_dir/VpredecodeTb || true)
echo "$simOut"

if grep -qx "Everything OK" <<< "$simOut"; then
  exit 0
else
  exit 1
fi
